// File: bench/spi_cmd_check.sv
`timescale 1ns/1ps

module spi_cmd_check (
  input  logic                               clk,
  input  logic                               rst_n,
  input  spi_cmd_pkg::spi_cmd_t              cmd_in,
  input  logic                               cmd_vld,
  input  logic                               cmd_rdy,
  input  logic                               read_vld,
  input  logic [spi_cmd_pkg::READ_WIDTH-1:0] read_data,
  output int                                 error_count,
  output int                                 read_count,
  output int                                 accepted_reads,
  output int                                 outstanding
);

  logic [spi_cmd_pkg::READ_WIDTH-1:0] image [8];
  logic [spi_cmd_pkg::READ_WIDTH-1:0] expect_q [$];
  logic [spi_cmd_pkg::READ_WIDTH-1:0] expected;

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 8; i++)
        image[i] = '0;
      expect_q.delete();
      error_count    = 0;
      read_count     = 0;
      accepted_reads = 0;
      outstanding    = 0;
    end
    else
    begin
      if (read_vld)
      begin
        read_count++;  // every pulse counts, expected or not
        if (expect_q.size() == 0)
        begin
          error_count++;
          $display("read_vld pulsed at %0d ns with no read outstanding", $time);
        end
        else
        begin
          expected = expect_q.pop_front();
          if (read_data !== expected)
          begin
            error_count++;
            $display("[FAIL] %0d ns: read %0d expected %02h got %02h",
                     $time, read_count, expected, read_data);
          end
        end
      end
      // the image follows command order as the host hands words over
      if (cmd_vld && cmd_rdy)
      begin
        if (cmd_in.write)
          image[cmd_in.addr] = cmd_in.data;
        else
        begin
          expect_q.push_back(image[cmd_in.addr]);
          accepted_reads++;
        end
      end
      outstanding = expect_q.size();
    end
  end

endmodule

// File: bench/spi_cmd_props.sv
`timescale 1ns/1ps

module spi_cmd_props (
  input  logic clk,
  input  logic rst_n,
  input  logic cs,
  input  logic sclk_rise,
  input  logic sclk_fall,
  input  logic read_vld
);

  logic sclk_level;  // sclk level as the strobes imply it
  int   rise_cnt;
  int   high_cnt;
  logic addr_done;   // the last cs low window was a read address frame

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sclk_level <= 1'b0;
      rise_cnt   <= 0;
      high_cnt   <= 0;
      addr_done  <= 1'b0;
    end
    else
    begin
      if (sclk_rise)
        sclk_level <= 1'b1;
      else if (sclk_fall)
        sclk_level <= 1'b0;
      if (cs)
        rise_cnt <= 0;
      else if (sclk_rise)
        rise_cnt <= rise_cnt + 1;
      if (cs)
        high_cnt <= high_cnt + 1;
      else
        high_cnt <= 0;
      if (!cs)
        addr_done <= 1'b0;
      else if (rise_cnt == spi_cmd_pkg::ADDR_BITS)
        addr_done <= 1'b1;
    end
  end

  a_sclk_idle: assert property (@(posedge clk) disable iff (!rst_n) cs |-> !sclk_level)
    else $error("sclk is high while cs is high");

  // the result comes in the cycle where cs rises after an eight bit window
  a_read_vld_cs: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld |-> ($rose(cs) && rise_cnt == spi_cmd_pkg::READ_WIDTH))
    else $error("read_vld pulsed outside the cycle that closes a read data window");

  a_turnaround: assert property (@(posedge clk) disable iff (!rst_n)
    ($fell(cs) && addr_done) |-> high_cnt == spi_cmd_pkg::TURN_DELAY)
    else $error("read turnaround lasted %0d cycles", high_cnt);

  a_window_len: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cs) |-> (rise_cnt == spi_cmd_pkg::CMD_WIDTH ||
                   rise_cnt == spi_cmd_pkg::ADDR_BITS ||
                   rise_cnt == spi_cmd_pkg::READ_WIDTH))
    else $error("cs low window closed after %0d sclk rises", rise_cnt);

endmodule

bind spi_frame_fsm spi_cmd_props props_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .cs        (cs),
  .sclk_rise (sclk_rise),
  .sclk_fall (sclk_fall),
  .read_vld  (read_vld)
);

// File: bench/spi_cmd_tb.sv
`timescale 1ns/1ps

module spi_cmd_tb;

  localparam int CLK_HALF       = 20;
  localparam int DRIVE_DLY      = 2;
  localparam int RESET_CYCLES   = 16;
  localparam int CMD_COUNT      = 60;
  localparam int BIT_CYCLES     = 2 * spi_cmd_pkg::SCLK_HALF;
  localparam int CMD_CYCLES     = (12 + 4 + 8) * BIT_CYCLES + 100 + 20;
  localparam int TIMEOUT_CYCLES = CMD_COUNT * CMD_CYCLES + RESET_CYCLES;

  logic                               clk = 1'b0;
  logic                               rst_n;
  spi_cmd_pkg::spi_cmd_t              cmd_in;
  logic                               cmd_vld;
  logic                               cmd_rdy;
  logic                               sclk;
  logic                               cs;
  logic                               mosi;
  logic                               miso;
  logic                               read_vld;
  logic [spi_cmd_pkg::READ_WIDTH-1:0] read_data;
  int                                 error_count;
  int                                 read_count;
  int                                 accepted_reads;
  int                                 outstanding;
  int                                 bench_errors;
  int                                 cycle_count;
  logic [31:0]                        lfsr_state;

  always #CLK_HALF clk = ~clk;

  spi_cmd_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .miso      (miso),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_slave_model slave_i (
    .clk   (clk),
    .rst_n (rst_n),
    .cs    (cs),
    .sclk  (sclk),
    .mosi  (mosi),
    .miso  (miso)
  );

  spi_cmd_check check_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .cmd_in         (cmd_in),
    .cmd_vld        (cmd_vld),
    .cmd_rdy        (cmd_rdy),
    .read_vld       (read_vld),
    .read_data      (read_data),
    .error_count    (error_count),
    .read_count     (read_count),
    .accepted_reads (accepted_reads),
    .outstanding    (outstanding)
  );

  // taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      bits = {bits[30:0], lfsr_state[0]};
    end
  endtask

  task automatic push_cmd(input spi_cmd_pkg::spi_cmd_t cmd);
    logic taken;
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    do
    begin
      @(negedge clk);
      taken = cmd_rdy;  // cmd_rdy only moves on rising edges
      @(posedge clk);
      #DRIVE_DLY;
    end
    while (!taken);
    cmd_vld = 1'b0;
  endtask

  initial
  begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("run timed out after %0d cycles", TIMEOUT_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial
  begin
    logic [31:0]           bits;
    spi_cmd_pkg::spi_cmd_t cmd;
    rst_n        = 1'b0;
    cmd_in       = '0;
    cmd_vld      = 1'b0;
    bench_errors = 0;
    lfsr_state   = 32'h483f;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    for (int n = 0; n < CMD_COUNT; n++)
    begin
      take_bits(1, bits);
      cmd.write = bits[0];
      take_bits(3, bits);
      cmd.addr = bits[2:0];
      take_bits(8, bits);
      cmd.data = bits[7:0];
      push_cmd(cmd);
      take_bits(2, bits);
      repeat (bits[1:0])
      begin
        @(posedge clk);
        #DRIVE_DLY;
      end
    end
    do
      @(negedge clk);
    while (outstanding != 0);
    if (read_count != accepted_reads)
    begin
      bench_errors++;
      $display("[FAIL] %0d ns: %0d read results came back for %0d accepted reads",
               $time, read_count, accepted_reads);
    end
    $display("errors %0d, reads checked %0d of %0d accepted",
             error_count + bench_errors, read_count, accepted_reads);
    if (error_count + bench_errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: bench/spi_slave_model.sv
`timescale 1ns/1ps

// The pins are oversampled on clk, so each sclk or cs edge is seen one clk
// cycle after it happens, well inside a half sclk period.
module spi_slave_model (
  input  logic clk,
  input  logic rst_n,
  input  logic cs,
  input  logic sclk,
  input  logic mosi,
  output logic miso
);

  logic [spi_cmd_pkg::READ_WIDTH-1:0]       regs [8];
  logic [$bits(spi_cmd_pkg::spi_cmd_t)-1:0] rx_bits;
  spi_cmd_pkg::spi_cmd_t                    rx_word;
  logic                                     sclk_q;
  logic                                     cs_q;
  int                                       bit_cnt;
  logic                                     rd_pending;
  logic [2:0]                               rd_addr;
  logic [2:0]                               rd_idx;

  assign rx_word = rx_bits;
  assign miso    = (!cs && rd_pending) ? regs[rd_addr][3'd7 - rd_idx] : 1'b0;  // MSB at cs fall

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 8; i++)
        regs[i] <= '0;
      rx_bits    <= '0;
      sclk_q     <= 1'b0;
      cs_q       <= 1'b1;
      bit_cnt    <= 0;
      rd_pending <= 1'b0;
      rd_addr    <= '0;
      rd_idx     <= '0;
    end
    else
    begin
      sclk_q <= sclk;
      cs_q   <= cs;
      if (!cs && sclk && !sclk_q)
      begin
        rx_bits <= {rx_bits[$bits(rx_bits)-2:0], mosi};
        bit_cnt <= bit_cnt + 1;
      end
      if (!cs && !sclk && sclk_q)
        rd_idx <= rd_idx + 3'd1;  // next read bit after each falling sclk
      if (cs && !cs_q)
      begin
        case (bit_cnt)
          12: regs[rx_word.addr] <= rx_word.data;
          4:
          begin
            rd_pending <= 1'b1;
            rd_addr    <= rx_bits[2:0];
          end
          8:       rd_pending <= 1'b0;
          default: rd_pending <= rd_pending;
        endcase
        bit_cnt <= 0;
        rd_idx  <= '0;
      end
    end
  end

endmodule

// File: rtl/spi_cmd_pkg.sv
package spi_cmd_pkg;

  // one command word as pushed by the host with the MSB sent first
  typedef struct packed {
    logic       write;  // 1 selects a write frame
    logic [2:0] addr;
    logic [7:0] data;   // don't care on reads
  } spi_cmd_t;

  typedef enum logic [3:0] {
    IDLE     = 4'd0,
    LOAD     = 4'd1,
    W_DATA   = 4'd2,
    W_FINISH = 4'd3,
    R_ADDR   = 4'd4,
    R_DELAY  = 4'd5,
    R_DATA   = 4'd6,
    R_FINISH = 4'd7
  } spi_state_e;

  localparam int CMD_WIDTH   = 12;   // bits in a write frame
  localparam int ADDR_BITS   = 4;    // flag plus address on a read
  localparam int READ_WIDTH  = 8;
  localparam int SCLK_HALF   = 4;    // clk cycles per sclk half period
  localparam int TURN_DELAY  = 100;  // cs high cycles between read frames
  localparam int QUEUE_DEPTH = 8;

  // counter widths derived from the figures above
  localparam int QUEUE_AW = $clog2(QUEUE_DEPTH);
  localparam int HALF_W   = $clog2(SCLK_HALF);
  localparam int CNT_W    = $clog2(CMD_WIDTH + 1);
  localparam int DLY_W    = $clog2(TURN_DELAY);

  localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(SCLK_HALF - 1);
  localparam logic [DLY_W-1:0]  DLY_LAST  = DLY_W'(TURN_DELAY - 1);

  // rise counts that close each kind of cs low window
  localparam logic [CNT_W-1:0] CMD_CNT  = CNT_W'(CMD_WIDTH);
  localparam logic [CNT_W-1:0] ADDR_CNT = CNT_W'(ADDR_BITS);
  localparam logic [CNT_W-1:0] READ_CNT = CNT_W'(READ_WIDTH);

endpackage

// File: rtl/spi_cmd_queue.sv
`timescale 1ns/1ps

module spi_cmd_queue (
  input  logic                  clk,
  input  logic                  rst_n,
  input  spi_cmd_pkg::spi_cmd_t cmd_in,
  input  logic                  cmd_vld,
  input  logic                  pop,
  output logic                  cmd_rdy,
  output spi_cmd_pkg::spi_cmd_t head,
  output logic                  head_vld
);

  spi_cmd_pkg::spi_cmd_t               mem [spi_cmd_pkg::QUEUE_DEPTH];
  logic [spi_cmd_pkg::QUEUE_AW-1:0]    wr_ptr;
  logic [spi_cmd_pkg::QUEUE_AW-1:0]    rd_ptr;
  logic [spi_cmd_pkg::QUEUE_AW:0]      count;
  logic                                push;
  logic                                take;

  // depth is a power of two, so the top count bit alone means full
  assign cmd_rdy  = ~count[spi_cmd_pkg::QUEUE_AW];
  assign head_vld = |count;
  assign head     = mem[rd_ptr];

  assign push = cmd_vld & cmd_rdy;
  assign take = pop & head_vld;

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= cmd_in;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;  // wraps at the buffer end
      if (take)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      count <= '0;
    else
    begin
      case ({push, take})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither leave occupancy alone
      endcase
    end
  end

endmodule

// File: rtl/spi_cmd_top.sv
`timescale 1ns/1ps

module spi_cmd_top (
  input  logic                                clk,
  input  logic                                rst_n,
  input  spi_cmd_pkg::spi_cmd_t               cmd_in,
  input  logic                                cmd_vld,
  input  logic                                miso,
  output logic                                cmd_rdy,
  output logic                                sclk,
  output logic                                cs,
  output logic                                mosi,
  output logic                                read_vld,
  output logic [spi_cmd_pkg::READ_WIDTH-1:0]  read_data
);

  spi_cmd_pkg::spi_cmd_t head;
  logic                  head_vld;
  logic                  pop;
  logic                  run;
  logic                  sclk_rise;
  logic                  sclk_fall;

  spi_cmd_queue queue_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .pop      (pop),
    .cmd_rdy  (cmd_rdy),
    .head     (head),
    .head_vld (head_vld)
  );

  spi_sclk_gen sclk_gen_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .run       (run),
    .sclk      (sclk),
    .sclk_rise (sclk_rise),
    .sclk_fall (sclk_fall)
  );

  spi_frame_fsm frame_fsm_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .head      (head),
    .head_vld  (head_vld),
    .sclk_rise (sclk_rise),
    .sclk_fall (sclk_fall),
    .miso      (miso),
    .pop       (pop),
    .run       (run),
    .cs        (cs),
    .mosi      (mosi),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

endmodule

// File: rtl/spi_frame_fsm.sv
`timescale 1ns/1ps

module spi_frame_fsm (
  input  logic                                clk,
  input  logic                                rst_n,
  input  spi_cmd_pkg::spi_cmd_t               head,
  input  logic                                head_vld,
  input  logic                                sclk_rise,
  input  logic                                sclk_fall,
  input  logic                                miso,
  output logic                                pop,
  output logic                                run,
  output logic                                cs,
  output logic                                mosi,
  output logic                                read_vld,
  output logic [spi_cmd_pkg::READ_WIDTH-1:0]  read_data
);

  spi_cmd_pkg::spi_state_e                state;
  spi_cmd_pkg::spi_state_e                state_nxt;
  spi_cmd_pkg::spi_cmd_t                  cmd_reg;
  logic [spi_cmd_pkg::CMD_WIDTH-1:0]      tx_sr;
  logic [spi_cmd_pkg::READ_WIDTH-1:0]     rx_sr;
  logic [spi_cmd_pkg::CNT_W-1:0]          bit_cnt;
  logic [spi_cmd_pkg::DLY_W-1:0]          dly_cnt;

  assign pop = (state == spi_cmd_pkg::IDLE) & head_vld;

  // the clock runs exactly while one of the three shifting windows is open
  assign run = (state == spi_cmd_pkg::W_DATA) |
               (state == spi_cmd_pkg::R_ADDR) |
               (state == spi_cmd_pkg::R_DATA);
  assign cs  = ~run;

  assign mosi      = tx_sr[spi_cmd_pkg::CMD_WIDTH-1];
  assign read_vld  = (state == spi_cmd_pkg::R_FINISH);
  assign read_data = rx_sr;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= spi_cmd_pkg::IDLE;
    else
      state <= state_nxt;
  end

  // Every window closes on the falling sclk edge after its last rise,
  // which drops cs together with sclk and keeps whole sclk periods.
  always_comb
  begin
    state_nxt = state;
    case (state)
      spi_cmd_pkg::IDLE:
        if (head_vld)
          state_nxt = spi_cmd_pkg::LOAD;
      spi_cmd_pkg::LOAD:
        if (cmd_reg.write)
          state_nxt = spi_cmd_pkg::W_DATA;
        else
          state_nxt = spi_cmd_pkg::R_ADDR;
      spi_cmd_pkg::W_DATA:
        if (sclk_fall && bit_cnt == spi_cmd_pkg::CMD_CNT)
          state_nxt = spi_cmd_pkg::W_FINISH;
      spi_cmd_pkg::W_FINISH:
        state_nxt = spi_cmd_pkg::IDLE;
      spi_cmd_pkg::R_ADDR:
        if (sclk_fall && bit_cnt == spi_cmd_pkg::ADDR_CNT)
          state_nxt = spi_cmd_pkg::R_DELAY;
      spi_cmd_pkg::R_DELAY:
        if (dly_cnt == spi_cmd_pkg::DLY_LAST)
          state_nxt = spi_cmd_pkg::R_DATA;
      spi_cmd_pkg::R_DATA:
        if (sclk_fall && bit_cnt == spi_cmd_pkg::READ_CNT)
          state_nxt = spi_cmd_pkg::R_FINISH;
      spi_cmd_pkg::R_FINISH:
        state_nxt = spi_cmd_pkg::IDLE;
      default:
        state_nxt = spi_cmd_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (pop)
      cmd_reg <= head;  // the queue moves on at this edge
  end

  // mosi is the top bit of tx_sr and rests low between frames
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      tx_sr <= '0;
    else if (state == spi_cmd_pkg::LOAD)
    begin
      if (cmd_reg.write)
        tx_sr <= cmd_reg;
      else
        tx_sr <= {cmd_reg.write, cmd_reg.addr, {$bits(cmd_reg.data){1'b0}}};
    end
    else if (run && sclk_fall)
      tx_sr <= {tx_sr[spi_cmd_pkg::CMD_WIDTH-2:0], 1'b0};  // zeros trail each frame
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      bit_cnt <= '0;
    else if (!run)
      bit_cnt <= '0;  // fresh count for each cs low window
    else if (sclk_rise)
      bit_cnt <= bit_cnt + 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      dly_cnt <= '0;
    else if (state == spi_cmd_pkg::R_DELAY)
      dly_cnt <= dly_cnt + 1'b1;
    else
      dly_cnt <= '0;
  end

  always_ff @(posedge clk)
  begin
    if (state == spi_cmd_pkg::R_DATA && sclk_rise)
      rx_sr <= {rx_sr[spi_cmd_pkg::READ_WIDTH-2:0], miso};  // sampled as sclk rises
  end

endmodule

// File: rtl/spi_sclk_gen.sv
`timescale 1ns/1ps

// The strobes are high in the cycle that ends with the sclk toggle, so
// logic acting on them updates on the same clk edge that moves sclk.
module spi_sclk_gen (
  input  logic clk,
  input  logic rst_n,
  input  logic run,
  output logic sclk,
  output logic sclk_rise,
  output logic sclk_fall
);

  logic [spi_cmd_pkg::HALF_W-1:0] half_cnt;
  logic                           half_end;

  assign half_end  = run & (half_cnt == spi_cmd_pkg::HALF_LAST);
  assign sclk_rise = half_end & ~sclk;
  assign sclk_fall = half_end & sclk;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      half_cnt <= '0;
      sclk     <= 1'b0;
    end
    else if (!run)
    begin
      half_cnt <= '0;  // sclk idles low between frames in mode 0
      sclk     <= 1'b0;
    end
    else if (half_end)
    begin
      half_cnt <= '0;
      sclk     <= ~sclk;
    end
    else
      half_cnt <= half_cnt + 1'b1;
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# compile the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module spi_cmd_tb \
  -f spi_cmd.f \
  -o spi_cmd_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/spi_cmd_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "^SIMULATION PASSED$"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: spi_cmd.f
rtl/spi_cmd_pkg.sv
rtl/spi_cmd_queue.sv
rtl/spi_sclk_gen.sv
rtl/spi_frame_fsm.sv
rtl/spi_cmd_top.sv
bench/spi_cmd_props.sv
bench/spi_slave_model.sv
bench/spi_cmd_check.sv
bench/spi_cmd_tb.sv
